/* list.f */
common/l1d_pkg.sv
common/l1d_cpu_if.sv
common/l1d_mem_if.sv
hdl/l1d_cpu_port.sv
hdl/l1d_mem_port.sv
l1d_core/l1d_cache_array.sv
l1d_core/l1d_controller.sv
hdl/l1d_top.sv
bench/l1d_mem_model.sv
bench/tb_l1d_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_l1d_top \
    -f list.f

output="$(./obj_dir/Vtb_l1d_top)"
echo "$output"

if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* bench/tb_l1d_top.sv */
`timescale 1ns/1ps

module tb_l1d_top;
    import l1d_pkg::*;

    localparam int NUM_SETS       = 16;
    localparam int NUM_WAYS       = 2;
    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 5;
    localparam int RESET_CYCLES   = 8;
    localparam int RAND_OPS       = 200;
    localparam int BLOCK_BYTES    = BLOCK_W / 8;
    // Five directed requests and the set overflow, then the random run
    localparam int NUM_REQ        = 5 + 2 * (NUM_WAYS + 1) + RAND_OPS;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + RESET_CYCLES;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        req_valid_i;
    logic        req_ready_o;
    logic        req_write_i;
    addr_t       req_addr_i;
    word_t       req_wdata_i;
    logic        resp_valid_o;
    logic        resp_ready_i;
    word_t       resp_rdata_o;
    logic        mem_req_valid_o;
    logic        mem_req_ready_i;
    logic        mem_req_write_o;
    addr_t       mem_req_addr_o;
    block_t      mem_req_block_o;
    logic        mem_resp_valid_i;
    logic        mem_resp_ready_o;
    block_t      mem_resp_block_i;
    int unsigned mem_write_count;

    word_t       sb_q [addr_t];
    int          err_count   = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          errs_before;
    int          checks_before;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    l1d_top #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) l1d_top_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_write_i      (req_write_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .resp_valid_o     (resp_valid_o),
        .resp_ready_i     (resp_ready_i),
        .resp_rdata_o     (resp_rdata_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_write_o  (mem_req_write_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_block_o  (mem_req_block_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_block_i (mem_resp_block_i)
    );

    l1d_mem_model #(
        .DRIVE_DLY (DRIVE_DLY)
    ) l1d_mem_model_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (mem_req_valid_o),
        .req_ready_o   (mem_req_ready_i),
        .req_write_i   (mem_req_write_o),
        .req_addr_i    (mem_req_addr_o),
        .req_block_i   (mem_req_block_o),
        .resp_valid_o  (mem_resp_valid_i),
        .resp_ready_i  (mem_resp_ready_o),
        .resp_block_o  (mem_resp_block_i),
        .write_count_o (mem_write_count)
    );

    // Memory starts at address XOR pattern until written
    function automatic word_t expected_word(input addr_t addr);
        if (sb_q.exists(addr)) begin
            return sb_q[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic start_test();
        errs_before   = err_count;
        checks_before = check_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s finished: %0d checks, %0d errors", name,
                 check_count - checks_before, err_count - errs_before);
    endtask

    // Holds the request until the DUT takes it
    task automatic issue(input logic write, input addr_t addr, input word_t wdata);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        step();
        req_valid_i = 1'b0;
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        issue(1'b1, addr, data);
        sb_q[addr] = data;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        step();
    endtask

    task automatic read_word(input addr_t addr, output word_t data);
        issue(1'b0, addr, '0);
        @(negedge clk_i);
        while (!resp_valid_o) begin
            @(negedge clk_i);
        end
        data = resp_rdata_o;
        step();
    endtask

    task automatic read_and_check(input addr_t addr);
        word_t got;
        read_word(addr, got);
        check_word($sformatf("read of %h", addr), got, expected_word(addr));
    endtask

    task automatic test_reset_state();
        start_test();
        @(negedge clk_i);
        check_flag("req_ready_o", req_ready_o, 1'b1);
        check_flag("resp_valid_o", resp_valid_o, 1'b0);
        check_flag("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check_flag("mem_resp_ready_o", mem_resp_ready_o, 1'b0);
        step();
        end_test("reset_state");
    endtask

    task automatic test_read_miss();
        start_test();
        read_and_check(32'h0000_0100);
        read_and_check(32'h0000_0104);
        end_test("read_miss_refill");
    endtask

    task automatic test_write_read();
        start_test();
        write_word(32'h0000_0208, 32'hDEAD_BEEF);
        read_and_check(32'h0000_0208);
        end_test("write_then_read");
    endtask

    task automatic test_dirty_evict();
        int unsigned count0;
        addr_t       addr;
        start_test();
        count0 = mem_write_count;
        // Same set index with a different tag for each address
        for (int k = 0; k <= NUM_WAYS; k++) begin
            addr = 32'h0000_2034 + k * NUM_SETS * BLOCK_BYTES;
            write_word(addr, 32'h1234_0000 + k);
        end
        for (int k = 0; k <= NUM_WAYS; k++) begin
            addr = 32'h0000_2034 + k * NUM_SETS * BLOCK_BYTES;
            read_and_check(addr);
        end
        check_count++;
        assert (mem_write_count > count0) else begin
            $display("No write-back reached memory after the set overflowed");
            err_count++;
        end
        end_test("dirty_eviction");
    endtask

    task automatic test_backpressure();
        word_t held;
        start_test();
        resp_ready_i = 1'b0;
        issue(1'b0, 32'h0000_030C, '0);
        @(negedge clk_i);
        while (!resp_valid_o) begin
            @(negedge clk_i);
        end
        held = resp_rdata_o;
        repeat (6) begin
            step();
            @(negedge clk_i);
            check_flag("resp_valid_o held", resp_valid_o, 1'b1);
            check_word("resp_rdata_o held", resp_rdata_o, held);
            check_flag("req_ready_o held", req_ready_o, 1'b0);
        end
        step();
        resp_ready_i = 1'b1;
        step();
        check_word("read of 0000030c", held, expected_word(32'h0000_030C));
        end_test("response_backpressure");
    endtask

    task automatic test_random();
        int unsigned w;
        int unsigned b;
        addr_t       addr;
        start_test();
        for (int n = 0; n < RAND_OPS; n++) begin
            w = $urandom_range(63, 0);
            b = w / 4;
            // Sixteen blocks over four sets so ways run out and get evicted
            addr = 32'h0000_8000 + (b % 4) * BLOCK_BYTES
                 + (b / 4) * NUM_SETS * BLOCK_BYTES + (w % 4) * 4;
            if ($urandom_range(1, 0) == 1) begin
                write_word(addr, $urandom());
            end else begin
                read_and_check(addr);
            end
        end
        end_test("random_traffic");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int unsigned seed_ret;
        seed_ret     = $urandom(98);
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        resp_ready_i = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
        end
        #DRIVE_DLY;
        rstn_i = 1'b1;

        test_reset_state();
        test_read_miss();
        test_write_read();
        test_dirty_evict();
        test_backpressure();
        test_random();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/l1d_mem_model.sv */
`timescale 1ns/1ps

module l1d_mem_model #(
    parameter int DRIVE_DLY = 5
) (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  logic             req_write_i,
    input  l1d_pkg::addr_t   req_addr_i,
    input  l1d_pkg::block_t  req_block_i,

    output logic             resp_valid_o,
    input  logic             resp_ready_i,
    output l1d_pkg::block_t  resp_block_o,

    output int unsigned      write_count_o
);
    import l1d_pkg::*;

    localparam int WORDS = BLOCK_W / WORD_W;

    // Words written so far, by byte address
    word_t mem_q [addr_t];

    function automatic word_t load_word(input addr_t addr);
        if (mem_q.exists(addr)) begin
            return mem_q[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic wait_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
    endtask

    initial begin
        addr_t  base;
        logic   is_write;
        block_t blk;
        req_ready_o   = 1'b0;
        resp_valid_o  = 1'b0;
        resp_block_o  = '0;
        write_count_o = 0;
        forever begin
            wait_cycles(1);
            if (rstn_i && req_valid_i) begin
                // Payload is held until the transfer, so take it now
                base     = {req_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                is_write = req_write_i;
                blk      = req_block_i;
                wait_cycles($urandom_range(4, 0));
                req_ready_o = 1'b1;
                wait_cycles(1);
                req_ready_o = 1'b0;
                if (is_write) begin
                    for (int i = 0; i < WORDS; i++) begin
                        mem_q[base + 4 * i] = blk[i*WORD_W +: WORD_W];
                    end
                    write_count_o++;
                end else begin
                    for (int i = 0; i < WORDS; i++) begin
                        blk[i*WORD_W +: WORD_W] = load_word(base + 4 * i);
                    end
                    wait_cycles($urandom_range(4, 0));
                    resp_block_o = blk;
                    resp_valid_o = 1'b1;
                    @(negedge clk_i);
                    while (!resp_ready_i) begin
                        @(negedge clk_i);
                    end
                    wait_cycles(1);
                    resp_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/l1d_top.sv */
`timescale 1ns/1ps

module l1d_top #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  logic             req_write_i,
    input  l1d_pkg::addr_t   req_addr_i,
    input  l1d_pkg::word_t   req_wdata_i,

    output logic             resp_valid_o,
    input  logic             resp_ready_i,
    output l1d_pkg::word_t   resp_rdata_o,

    output logic             mem_req_valid_o,
    input  logic             mem_req_ready_i,
    output logic             mem_req_write_o,
    output l1d_pkg::addr_t   mem_req_addr_o,
    output l1d_pkg::block_t  mem_req_block_o,

    input  logic             mem_resp_valid_i,
    output logic             mem_resp_ready_o,
    input  l1d_pkg::block_t  mem_resp_block_i
);
    import l1d_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = ADDR_W - OFFSET_W - $clog2(NUM_SETS);

    l1d_cpu_if cpu_if_inst ();
    l1d_mem_if mem_if_inst ();

    addr_t            lookup_addr;
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    block_t           rd_block;
    logic             wr_en;
    logic [WAY_W-1:0] wr_way;
    block_t           wr_block;
    addr_t            wr_tag_addr;
    logic             wr_dirty;
    logic             wr_valid;
    logic             advance_victim;

    l1d_cpu_port l1d_cpu_port_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o),
        .core         (cpu_if_inst.cpu_port)
    );

    l1d_controller #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) l1d_controller_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .cpu              (cpu_if_inst.core),
        .mem              (mem_if_inst.core),
        .lookup_addr_o    (lookup_addr),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .rd_block_i       (rd_block),
        .wr_en_o          (wr_en),
        .wr_way_o         (wr_way),
        .wr_block_o       (wr_block),
        .wr_tag_addr_o    (wr_tag_addr),
        .wr_dirty_o       (wr_dirty),
        .wr_valid_o       (wr_valid),
        .advance_victim_o (advance_victim)
    );

    l1d_cache_array #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) l1d_cache_array_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .lookup_addr_i    (lookup_addr),
        .hit_o            (hit),
        .hit_way_o        (hit_way),
        .victim_way_o     (victim_way),
        .victim_dirty_o   (victim_dirty),
        .victim_tag_o     (victim_tag),
        .rd_block_o       (rd_block),
        .wr_en_i          (wr_en),
        .wr_way_i         (wr_way),
        .wr_block_i       (wr_block),
        .wr_tag_addr_i    (wr_tag_addr),
        .wr_dirty_i       (wr_dirty),
        .wr_valid_i       (wr_valid),
        .advance_victim_i (advance_victim)
    );

    l1d_mem_port l1d_mem_port_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .bus              (mem_if_inst.bus),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_write_o  (mem_req_write_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_block_o  (mem_req_block_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_block_i (mem_resp_block_i)
    );

endmodule

/* l1d_core/l1d_controller.sv */
`timescale 1ns/1ps

module l1d_controller #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,

    l1d_cpu_if.core                                            cpu,
    l1d_mem_if.core                                            mem,

    output l1d_pkg::addr_t                                     lookup_addr_o,
    input  logic                                               hit_i,
    input  logic [$clog2(NUM_WAYS)-1:0]                        hit_way_i,
    input  logic [$clog2(NUM_WAYS)-1:0]                        victim_way_i,
    input  logic                                               victim_dirty_i,
    input  logic [l1d_pkg::ADDR_W-l1d_pkg::OFFSET_W-$clog2(NUM_SETS)-1:0] victim_tag_i,
    input  l1d_pkg::block_t                                    rd_block_i,

    output logic                                               wr_en_o,
    output logic [$clog2(NUM_WAYS)-1:0]                        wr_way_o,
    output l1d_pkg::block_t                                    wr_block_o,
    output l1d_pkg::addr_t                                     wr_tag_addr_o,
    output logic                                               wr_dirty_o,
    output logic                                               wr_valid_o,
    output logic                                               advance_victim_o
);
    import l1d_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int IDX_W = $clog2(NUM_SETS);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        REFILL
    } state_t;

    state_t           state_r;

    addr_t            addr_r;
    word_t            wdata_r;
    logic             write_r;
    logic [WAY_W-1:0] way_r;
    word_t            rdata_r;

    logic             mreq_valid_r;
    logic             mreq_write_r;
    addr_t            mreq_addr_r;
    block_t           mreq_block_r;

    addr_t            wb_addr;

    // Victim's own address, rebuilt from its tag and the request's index
    assign wb_addr = {victim_tag_i, addr_r[OFFSET_W +: IDX_W], {OFFSET_W{1'b0}}};

    assign lookup_addr_o = addr_r;

    assign cpu.ready  = (state_r == IDLE);
    assign cpu.rvalid = (state_r == RESPOND);
    assign cpu.rdata  = rdata_r;

    assign mem.req_valid = mreq_valid_r;
    assign mem.req_write = mreq_write_r;
    assign mem.req_addr  = mreq_addr_r;
    assign mem.req_block = mreq_block_r;

    always_comb begin
        wr_en_o          = 1'b0;
        wr_way_o         = hit_way_i;
        wr_block_o       = with_word(rd_block_i, addr_r, wdata_r);
        wr_tag_addr_o    = addr_r;
        wr_dirty_o       = 1'b1;
        wr_valid_o       = 1'b1;
        advance_victim_o = 1'b0;
        if (state_r == LOOKUP && hit_i && write_r) begin
            wr_en_o = 1'b1;
        end
        // Refilled block goes in clean
        if (state_r == REFILL && mem.resp_valid) begin
            wr_en_o          = 1'b1;
            wr_way_o         = way_r;
            wr_block_o       = mem.resp_block;
            wr_dirty_o       = 1'b0;
            advance_victim_o = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r      <= IDLE;
            mreq_valid_r <= 1'b0;
            mreq_write_r <= 1'b0;
        end else begin
            if (mem.req_valid && mem.req_ready) begin
                mreq_valid_r <= 1'b0;
            end
            case (state_r)
                IDLE: begin
                    if (cpu.valid) begin
                        state_r <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit_i) begin
                        state_r <= write_r ? IDLE : RESPOND;
                    end else begin
                        mreq_valid_r <= 1'b1;
                        mreq_write_r <= victim_dirty_i;
                        state_r      <= victim_dirty_i ? WRITEBACK : REFILL;
                    end
                end
                RESPOND: state_r <= IDLE;
                WRITEBACK: begin
                    if (mem.resp_valid) begin
                        mreq_valid_r <= 1'b1;
                        mreq_write_r <= 1'b0;
                        state_r      <= REFILL;
                    end
                end
                REFILL: begin
                    // Lookup again, it hits now
                    if (mem.resp_valid) begin
                        state_r <= LOOKUP;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cpu.valid && cpu.ready) begin
            addr_r  <= cpu.addr;
            wdata_r <= cpu.wdata;
            write_r <= cpu.write;
        end
        if (state_r == LOOKUP) begin
            way_r        <= victim_way_i;
            rdata_r      <= word_of_block(rd_block_i, addr_r);
            mreq_block_r <= rd_block_i;
            mreq_addr_r  <= victim_dirty_i ? wb_addr : block_addr(addr_r);
        end
        if (state_r == WRITEBACK && mem.resp_valid) begin
            mreq_addr_r <= block_addr(addr_r);
        end
    end

endmodule

/* l1d_core/l1d_cache_array.sv */
`timescale 1ns/1ps

module l1d_cache_array #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,

    input  l1d_pkg::addr_t                                     lookup_addr_i,
    output logic                                               hit_o,
    output logic [$clog2(NUM_WAYS)-1:0]                        hit_way_o,
    output logic [$clog2(NUM_WAYS)-1:0]                        victim_way_o,
    output logic                                               victim_dirty_o,
    output logic [l1d_pkg::ADDR_W-l1d_pkg::OFFSET_W-$clog2(NUM_SETS)-1:0] victim_tag_o,
    output l1d_pkg::block_t                                    rd_block_o,

    input  logic                                               wr_en_i,
    input  logic [$clog2(NUM_WAYS)-1:0]                        wr_way_i,
    input  l1d_pkg::block_t                                    wr_block_i,
    input  l1d_pkg::addr_t                                     wr_tag_addr_i,
    input  logic                                               wr_dirty_i,
    input  logic                                               wr_valid_i,
    input  logic                                               advance_victim_i
);
    import l1d_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    logic [TAG_W-1:0]    tag_r   [NUM_SETS][NUM_WAYS];
    block_t              data_r  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_r [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_r [NUM_SETS];
    logic [WAY_W-1:0]    rr_r;

    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic [IDX_W-1:0]    wr_idx;
    logic                free_found;

    assign idx    = lookup_addr_i[OFFSET_W +: IDX_W];
    assign tag    = lookup_addr_i[ADDR_W-1 -: TAG_W];
    assign wr_idx = wr_tag_addr_i[OFFSET_W +: IDX_W];

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        free_found   = 1'b0;
        victim_way_o = rr_r;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_r[idx][w] && tag_r[idx][w] == tag) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);
            end
            // Lowest invalid way wins over the round-robin pick
            if (!valid_r[idx][w] && !free_found) begin
                free_found   = 1'b1;
                victim_way_o = WAY_W'(w);
            end
        end
        victim_dirty_o = valid_r[idx][victim_way_o] && dirty_r[idx][victim_way_o];
        victim_tag_o   = tag_r[idx][victim_way_o];
        rd_block_o     = hit_o ? data_r[idx][hit_way_o] : data_r[idx][victim_way_o];
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
            end
            rr_r <= '0;
        end else begin
            if (wr_en_i) begin
                valid_r[wr_idx][wr_way_i] <= wr_valid_i;
                dirty_r[wr_idx][wr_way_i] <= wr_dirty_i;
            end
            if (advance_victim_i) begin
                rr_r <= rr_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_r[wr_idx][wr_way_i]  <= wr_tag_addr_i[ADDR_W-1 -: TAG_W];
            data_r[wr_idx][wr_way_i] <= wr_block_i;
        end
    end

endmodule

/* hdl/l1d_mem_port.sv */
`timescale 1ns/1ps

module l1d_mem_port (
    input  logic             clk_i,
    input  logic             rstn_i,

    l1d_mem_if.bus           bus,

    output logic             mem_req_valid_o,
    input  logic             mem_req_ready_i,
    output logic             mem_req_write_o,
    output l1d_pkg::addr_t   mem_req_addr_o,
    output l1d_pkg::block_t  mem_req_block_o,

    input  logic             mem_resp_valid_i,
    output logic             mem_resp_ready_o,
    input  l1d_pkg::block_t  mem_resp_block_i
);
    import l1d_pkg::*;

    typedef enum logic [1:0] {
        MP_IDLE,
        MP_REQ,
        MP_RESP,
        MP_DONE
    } mp_state_t;

    mp_state_t state_r;

    logic      req_write_r;
    addr_t     req_addr_r;
    block_t    req_block_r;
    block_t    resp_block_r;

    assign bus.req_ready  = (state_r == MP_IDLE);
    assign bus.resp_valid = (state_r == MP_DONE);
    assign bus.resp_block = resp_block_r;

    assign mem_req_valid_o  = (state_r == MP_REQ);
    assign mem_req_write_o  = req_write_r;
    assign mem_req_addr_o   = req_addr_r;
    assign mem_req_block_o  = req_block_r;
    assign mem_resp_ready_o = (state_r == MP_RESP);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= MP_IDLE;
        end else begin
            case (state_r)
                MP_IDLE: if (bus.req_valid) state_r <= MP_REQ;
                MP_REQ: begin
                    // Writes complete once memory takes them
                    if (mem_req_ready_i) begin
                        state_r <= req_write_r ? MP_DONE : MP_RESP;
                    end
                end
                MP_RESP: if (mem_resp_valid_i) state_r <= MP_DONE;
                default: state_r <= MP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.req_valid && bus.req_ready) begin
            req_write_r <= bus.req_write;
            req_addr_r  <= bus.req_addr;
            req_block_r <= bus.req_block;
        end
        if (mem_resp_valid_i && mem_resp_ready_o) begin
            resp_block_r <= mem_resp_block_i;
        end
    end

endmodule

/* hdl/l1d_cpu_port.sv */
`timescale 1ns/1ps

module l1d_cpu_port (
    input  logic            clk_i,
    input  logic            rstn_i,

    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  logic            req_write_i,
    input  l1d_pkg::addr_t  req_addr_i,
    input  l1d_pkg::word_t  req_wdata_i,

    output logic            resp_valid_o,
    input  logic            resp_ready_i,
    output l1d_pkg::word_t  resp_rdata_o,

    l1d_cpu_if.cpu_port     core
);
    import l1d_pkg::*;

    logic  buf_valid_r;
    logic  buf_write_r;
    addr_t buf_addr_r;
    word_t buf_wdata_r;

    logic  resp_valid_r;
    word_t resp_rdata_r;

    assign req_ready_o  = !buf_valid_r && !resp_valid_r;
    assign resp_valid_o = resp_valid_r;
    assign resp_rdata_o = resp_rdata_r;

    // Offer only with an empty response register so the read beat always lands
    assign core.valid = buf_valid_r && !resp_valid_r;
    assign core.write = buf_write_r;
    assign core.addr  = buf_addr_r;
    assign core.wdata = buf_wdata_r;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            buf_valid_r  <= 1'b0;
            resp_valid_r <= 1'b0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                buf_valid_r <= 1'b1;
            end else if (core.valid && core.ready) begin
                buf_valid_r <= 1'b0;
            end
            if (core.rvalid) begin
                resp_valid_r <= 1'b1;
            end else if (resp_ready_i) begin
                resp_valid_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            buf_write_r <= req_write_i;
            buf_addr_r  <= req_addr_i;
            buf_wdata_r <= req_wdata_i;
        end
        if (core.rvalid) begin
            resp_rdata_r <= core.rdata;
        end
    end

endmodule

/* common/l1d_mem_if.sv */
`timescale 1ns/1ps

interface l1d_mem_if;
    import l1d_pkg::*;

    logic   req_valid;
    logic   req_ready;
    logic   req_write;
    addr_t  req_addr;
    block_t req_block;

    // Completion pulse, carries the block for a refill
    logic   resp_valid;
    block_t resp_block;

    modport core (
        output req_valid, req_write, req_addr, req_block,
        input  req_ready, resp_valid, resp_block
    );

    modport bus (
        input  req_valid, req_write, req_addr, req_block,
        output req_ready, resp_valid, resp_block
    );

endinterface

/* common/l1d_cpu_if.sv */
`timescale 1ns/1ps

interface l1d_cpu_if;
    import l1d_pkg::*;

    logic  valid;
    logic  ready;
    logic  write;
    addr_t addr;
    word_t wdata;

    // Read data beat, one cycle wide
    logic  rvalid;
    word_t rdata;

    modport cpu_port (
        output valid, write, addr, wdata,
        input  ready, rvalid, rdata
    );

    modport core (
        input  valid, write, addr, wdata,
        output ready, rvalid, rdata
    );

endinterface

/* common/l1d_pkg.sv */
package l1d_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int BLOCK_W  = 128;
    localparam int OFFSET_W = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;

    // Word slot inside a block, byte offset without the low two bits
    function automatic word_t word_of_block(input block_t blk, input addr_t addr);
        return blk[addr[OFFSET_W-1:2]*WORD_W +: WORD_W];
    endfunction

    function automatic block_t with_word(input block_t blk, input addr_t addr, input word_t word);
        block_t merged;
        merged = blk;
        merged[addr[OFFSET_W-1:2]*WORD_W +: WORD_W] = word;
        return merged;
    endfunction

    // First byte of the block holding addr
    function automatic addr_t block_addr(input addr_t addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

endpackage
